//--- verilog/n64_proto_pkg.sv
package n64_proto_pkg;

    // command bytes sent by the host, MSB first
    localparam logic [7:0] cmd_get_buttons = 8'h01; // poll buttons and stick
    localparam logic [7:0] cmd_reset       = 8'hFF; // reset controller, answers with status

    // a write is the command byte plus one stop bit
    localparam int write_cells = 9;

    // bit cell timing in microseconds
    // scaled by clks_per_us in each module
    localparam int cell_us     = 4; // full cell, falling edge to falling edge
    localparam int zero_low_us = 3; // a 0 is long low, short high
    localparam int one_low_us  = 1; // a 1 is short low, long high

    // reader samples the line this long after each falling edge
    // halfway between the low time of a 1 and of a 0
    localparam int sample_us = 2;

    // no falling edge for this long ends the reply with an error
    // also covers a controller that never answers
    localparam int reply_timeout_us = 64;

endpackage

//--- verilog/n64_report_pkg.sv
package n64_report_pkg;

    // reply lengths in bits, per command
    localparam int button_reply_bits = 32; // get buttons, 4 bytes
    localparam int status_reply_bits = 24; // reset, 3 bytes

    // get buttons reply as it arrives on the wire, first bit at the top
    typedef struct packed {
        logic a;
        logic b;
        logic z;
        logic start;
        logic d_up;
        logic d_down;
        logic d_left;
        logic d_right;
        logic rsvd_reset;          // set by the pad when L+R+start held
        logic rsvd;
        logic l;
        logic r;
        logic c_up;
        logic c_down;
        logic c_left;
        logic c_right;
        logic signed [7:0] stick_x; // two's complement, right is positive
        logic signed [7:0] stick_y; // up is positive
    } button_view_t;

    // status reply, left aligned so the low byte is not part of the reply
    typedef struct packed {
        logic [15:0] device_id; // 0500h for a standard pad
        logic [7:0]  status;    // pak present, crc error bits
        logic [7:0]  unused;
    } status_view_t;

    // one reply word, read either way depending on the command sent
    typedef union packed {
        button_view_t button;
        status_view_t status;
    } reply_word_t;

endpackage

//--- verilog/n64_poll_timer.sv
`timescale 1ns/1ps

module n64_poll_timer #(
    parameter int poll_cycles = 4000 // poll period in clocks
) (
    input  logic clk,
    input  logic send_reset,
    input  logic polling_enable,
    input  logic controller_reset,
    output logic poll_start,
    output logic poll_reset
);

    localparam int cnt_w = (poll_cycles > 2) ? $clog2(poll_cycles) : 1;

    logic [cnt_w-1:0] period_cnt;   // position within the poll period
    logic             period_end;
    logic             ctrl_reset_q; // last value of controller_reset
    logic             reset_rise;
    logic             reset_pending; // sticky until the next poll goes out

    assign period_end = (period_cnt == cnt_w'(poll_cycles - 1));

    // shared start for all ports, never while polling is off
    assign poll_start = polling_enable & period_end;

    assign reset_rise = controller_reset & ~ctrl_reset_q;

    // the next poll carries a reset command when one is pending
    assign poll_reset = reset_pending;

    // period counter, held at zero while disabled so the first poll
    // comes one full period after enable
    always_ff @(posedge clk) begin
        if (send_reset) begin
            period_cnt <= '0;
        end else if (!polling_enable || period_end) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // edge detect on the reset request
    always_ff @(posedge clk) begin
        if (send_reset) begin
            ctrl_reset_q  <= 1'b0;
            reset_pending <= 1'b0;
        end else begin
            ctrl_reset_q <= controller_reset;
            if (reset_rise) begin
                reset_pending <= 1'b1; // new request wins over a poll in the same cycle
            end else if (poll_start) begin
                reset_pending <= 1'b0; // consumed by this poll
            end
        end
    end

endmodule

//--- verilog/n64_line_writer.sv
`timescale 1ns/1ps

module n64_line_writer #(
    parameter int clks_per_us = 4
) (
    input  logic       clk,
    input  logic       send_reset,
    input  logic       start,
    input  logic [7:0] command,
    output logic       line_low,
    output logic       busy,
    output logic       write_done
);

    localparam int cell_clks = n64_proto_pkg::cell_us * clks_per_us;
    localparam int zero_clks = n64_proto_pkg::zero_low_us * clks_per_us;
    localparam int one_clks  = n64_proto_pkg::one_low_us * clks_per_us;
    localparam int cnt_w     = $clog2(cell_clks);

    logic [cnt_w-1:0] cell_cnt; // clock within the current cell
    logic [3:0]       bit_idx;  // which cell, 0..8
    logic [8:0]       shift_q;  // command then stop bit, top bit is on the wire
    logic             cell_end;
    logic             low_time;

    assign cell_end = (cell_cnt == cnt_w'(cell_clks - 1));

    // long low for a 0, short low for a 1
    assign low_time = shift_q[8] ? (cell_cnt < cnt_w'(one_clks))
                                 : (cell_cnt < cnt_w'(zero_clks));

    assign line_low = busy & low_time; // released outside a write

    always_ff @(posedge clk) begin
        if (send_reset) begin
            busy       <= 1'b0;
            cell_cnt   <= '0;
            bit_idx    <= '0;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            if (start && !busy) begin
                busy     <= 1'b1;
                cell_cnt <= '0;
                bit_idx  <= '0;
            end else if (busy) begin
                if (cell_end) begin
                    cell_cnt <= '0;
                    bit_idx  <= bit_idx + 4'd1;
                    if (bit_idx == 4'(n64_proto_pkg::write_cells - 1)) begin
                        busy       <= 1'b0;
                        write_done <= 1'b1; // hands over to the reader
                    end
                end else begin
                    cell_cnt <= cell_cnt + 1'b1;
                end
            end
        end
    end

    // payload shift register, stop bit is a 1
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            shift_q <= {command, 1'b1};
        end else if (busy && cell_end) begin
            shift_q <= {shift_q[7:0], 1'b0};
        end
    end

endmodule

//--- verilog/n64_line_reader.sv
`timescale 1ns/1ps

module n64_line_reader #(
    parameter int clks_per_us = 4
) (
    input  logic                      clk,
    input  logic                      send_reset,
    input  logic                      start,
    input  logic                      line_in,
    input  logic [5:0]                reply_bits, // expected length of this reply
    output logic                      done,
    output logic                      error,
    output logic                      busy,
    output n64_report_pkg::reply_word_t word
);

    localparam int sample_clks  = n64_proto_pkg::sample_us * clks_per_us;
    localparam int timeout_clks = n64_proto_pkg::reply_timeout_us * clks_per_us;
    localparam int samp_w       = (sample_clks > 2) ? $clog2(sample_clks) : 1;
    localparam int tmo_w        = $clog2(timeout_clks);

    logic [1:0]        sync_q;    // two flop synchronizer, line idles high
    logic              line_prev; // for the falling edge
    logic              fall;
    logic              armed;     // waiting to sample the current cell
    logic [samp_w-1:0] samp_cnt;
    logic [tmo_w-1:0]  idle_cnt;  // clocks since the last falling edge
    logic [5:0]        bit_cnt;   // bits received so far
    logic              sample_now;
    logic              timed_out;
    logic [31:0]       word_q;

    assign fall       = line_prev & ~sync_q[1];
    assign sample_now = busy & armed & ~fall & (samp_cnt == samp_w'(sample_clks - 1));
    assign timed_out  = busy & ~fall & (idle_cnt == tmo_w'(timeout_clks - 1));
    assign word       = word_q;

    always_ff @(posedge clk) begin
        if (send_reset) begin
            sync_q    <= 2'b11;
            line_prev <= 1'b1;
            busy      <= 1'b0;
            armed     <= 1'b0;
            samp_cnt  <= '0;
            idle_cnt  <= '0;
            bit_cnt   <= '0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], line_in};
            line_prev <= sync_q[1];
            done      <= 1'b0;
            error     <= 1'b0;
            if (start && !busy) begin
                busy     <= 1'b1;
                armed    <= 1'b0;
                idle_cnt <= '0;
                bit_cnt  <= '0;
            end else if (busy) begin
                if (fall) begin        // new cell, start the sample timer
                    armed    <= 1'b1;
                    samp_cnt <= '0;
                    idle_cnt <= '0;
                end else if (timed_out) begin
                    busy  <= 1'b0;     // pad missing or reply cut short
                    armed <= 1'b0;
                    done  <= 1'b1;
                    error <= 1'b1;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                    if (armed) samp_cnt <= samp_cnt + 1'b1;
                    if (sample_now) begin
                        armed   <= 1'b0;
                        bit_cnt <= bit_cnt + 6'd1;
                        if (bit_cnt == reply_bits - 6'd1) begin
                            busy <= 1'b0; // stop bit that follows is ignored
                            done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // bits land MSB first from the top, short replies stay left aligned
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            word_q <= '0;
        end else if (sample_now) begin
            word_q[5'd31 - bit_cnt[4:0]] <= sync_q[1];
        end
    end

endmodule

//--- verilog/n64_port.sv
`timescale 1ns/1ps

module n64_port #(
    parameter int clks_per_us = 4
) (
    input  logic                        clk,
    input  logic                        send_reset,
    input  logic                        poll_start,
    input  logic                        poll_reset,
    input  logic                        line_in,
    output logic                        line_low,
    output logic                        reply_done,
    output logic                        reply_error,
    output logic                        reply_is_status,
    output n64_report_pkg::reply_word_t reply_word
);

    logic       write_busy;
    logic       write_done; // also starts the reader
    logic       read_busy;
    logic       port_busy;
    logic       poll_take;  // poll accepted by this port
    logic       cmd_is_reset;
    logic [7:0] command;
    logic [5:0] reply_bits;

    // write_done covers the one cycle between writer and reader
    assign port_busy = write_busy | write_done | read_busy;
    assign poll_take = poll_start & ~port_busy; // dropped while busy

    assign command = poll_reset ? n64_proto_pkg::cmd_reset : n64_proto_pkg::cmd_get_buttons;

    // reset answers with a status, everything else with buttons
    assign reply_bits = cmd_is_reset ? 6'(n64_report_pkg::status_reply_bits)
                                     : 6'(n64_report_pkg::button_reply_bits);

    assign reply_is_status = cmd_is_reset; // stable until the next accepted poll

    // remember which command went out, the reader needs its length
    always_ff @(posedge clk) begin
        if (send_reset) begin
            cmd_is_reset <= 1'b0;
        end else if (poll_take) begin
            cmd_is_reset <= poll_reset;
        end
    end

    // the only driver on the line, reader just listens
    n64_line_writer #(
        .clks_per_us(clks_per_us)
    ) writer_inst (
        .clk       (clk),
        .send_reset(send_reset),
        .start     (poll_take),
        .command   (command),
        .line_low  (line_low),
        .busy      (write_busy),
        .write_done(write_done)
    );

    n64_line_reader #(
        .clks_per_us(clks_per_us)
    ) reader_inst (
        .clk       (clk),
        .send_reset(send_reset),
        .start     (write_done),
        .line_in   (line_in),
        .reply_bits(reply_bits),
        .done      (reply_done),
        .error     (reply_error),
        .busy      (read_busy),
        .word      (reply_word)
    );

endmodule

//--- verilog/n64_report_collector.sv
`timescale 1ns/1ps

module n64_report_collector #(
    parameter int num_ports = 4
) (
    input  logic                        clk,
    input  logic                        send_reset,
    input  logic [num_ports-1:0]        reply_done,
    input  logic [num_ports-1:0]        reply_error,
    input  logic [num_ports-1:0]        reply_is_status,
    input  n64_report_pkg::reply_word_t reply_word [num_ports],
    output n64_report_pkg::reply_word_t button_data [num_ports],
    output n64_report_pkg::reply_word_t pad_status [num_ports],
    output logic [num_ports-1:0]        report_valid,
    output logic [num_ports-1:0]        report_error
);

    always_ff @(posedge clk) begin
        if (send_reset) begin
            report_valid <= '0;
            report_error <= '0;
            for (int i = 0; i < num_ports; i++) begin
                button_data[i] <= '0;
                pad_status[i]  <= '0;
            end
        end else begin
            // one pulse per finished reply, never both
            report_valid <= reply_done & ~reply_error;
            report_error <= reply_done & reply_error;
            for (int i = 0; i < num_ports; i++) begin
                if (reply_done[i] && !reply_error[i]) begin
                    if (reply_is_status[i]) begin
                        // only the 24 reply bits, low byte forced clear
                        pad_status[i].status.device_id <= reply_word[i].status.device_id;
                        pad_status[i].status.status    <= reply_word[i].status.status;
                        pad_status[i].status.unused    <= 8'h00;
                    end else begin
                        button_data[i] <= reply_word[i];
                    end
                end
                // a failed poll leaves the last good data in place
            end
        end
    end

endmodule

//--- verilog/n64_hub.sv
`timescale 1ns/1ps

module n64_hub #(
    parameter int num_ports   = 4,
    parameter int clks_per_us = 4,    // 100 on hardware
    parameter int poll_cycles = 4000  // 1 ms at 4 clocks per us
) (
    input  logic                        clk,
    input  logic                        send_reset,
    input  logic                        polling_enable,
    input  logic                        controller_reset,
    input  logic [num_ports-1:0]        line_in,
    output logic [num_ports-1:0]        line_low,
    output n64_report_pkg::reply_word_t button_data [num_ports],
    output n64_report_pkg::reply_word_t pad_status [num_ports],
    output logic [num_ports-1:0]        report_valid,
    output logic [num_ports-1:0]        report_error
);

    logic                        poll_start; // same pulse to every port
    logic                        poll_reset;
    logic [num_ports-1:0]        reply_done;
    logic [num_ports-1:0]        reply_error;
    logic [num_ports-1:0]        reply_is_status;
    n64_report_pkg::reply_word_t reply_word [num_ports];

    n64_poll_timer #(
        .poll_cycles(poll_cycles)
    ) poll_timer_inst (
        .clk             (clk),
        .send_reset      (send_reset),
        .polling_enable  (polling_enable),
        .controller_reset(controller_reset),
        .poll_start      (poll_start),
        .poll_reset      (poll_reset)
    );

    for (genvar i = 0; i < num_ports; i++) begin : gen_ports
        n64_port #(
            .clks_per_us(clks_per_us)
        ) port_inst (
            .clk            (clk),
            .send_reset     (send_reset),
            .poll_start     (poll_start),
            .poll_reset     (poll_reset),
            .line_in        (line_in[i]),
            .line_low       (line_low[i]),
            .reply_done     (reply_done[i]),
            .reply_error    (reply_error[i]),
            .reply_is_status(reply_is_status[i]),
            .reply_word     (reply_word[i])
        );
    end

    n64_report_collector #(
        .num_ports(num_ports)
    ) collector_inst (
        .clk            (clk),
        .send_reset     (send_reset),
        .reply_done     (reply_done),
        .reply_error    (reply_error),
        .reply_is_status(reply_is_status),
        .reply_word     (reply_word),
        .button_data    (button_data),
        .pad_status     (pad_status),
        .report_valid   (report_valid),
        .report_error   (report_error)
    );

endmodule

//--- tests/n64_controller_model.sv
`timescale 1ns/1ps

module n64_controller_model #(
    parameter int clks_per_us = 4
) (
    input  logic        clk,
    input  logic        line,        // wired-AND level seen on the cable
    input  logic [31:0] button_word, // answer to get buttons
    input  logic [23:0] status_word, // answer to reset
    input  logic        silent,      // pad unplugged, never answers
    output logic        drive_low,
    output logic [7:0]  last_command,
    output int          command_count
);

    localparam int cell_clks  = n64_proto_pkg::cell_us * clks_per_us;
    localparam int split_clks = n64_proto_pkg::sample_us * clks_per_us; // shorter low is a 1
    localparam int gap_clks   = 5 * clks_per_us; // quiet time before answering

    // one host cell, line looked at on the falling clock edge
    task automatic read_cell(output logic b);
        int low_clks;
        while (line) @(negedge clk);
        low_clks = 0;
        while (!line) begin
            @(negedge clk);
            low_clks++;
        end
        b = (low_clks < split_clks);
    endtask

    // one reply cell, drive changes just after the rising edge
    task automatic send_cell(input logic b);
        int low_clks;
        low_clks = b ? n64_proto_pkg::one_low_us * clks_per_us
                     : n64_proto_pkg::zero_low_us * clks_per_us;
        for (int c = 0; c < cell_clks; c++) begin
            @(posedge clk);
            #1;
            drive_low = (c < low_clks);
        end
    endtask

    initial begin
        logic [7:0] cmd;
        logic       b;
        drive_low     = 1'b0;
        last_command  = 8'h00;
        command_count = 0;
        @(negedge clk);
        forever begin
            for (int k = 7; k >= 0; k--) begin
                read_cell(b);
                cmd[k] = b; // MSB first
            end
            read_cell(b); // host stop bit
            last_command  = cmd;
            command_count = command_count + 1;
            if (!silent) begin
                repeat (gap_clks) @(posedge clk);
                if (cmd == 8'hFF) begin
                    for (int k = 23; k >= 0; k--) begin
                        send_cell(status_word[k]);
                    end
                    send_cell(1'b1); // stop
                end else if (cmd == 8'h01) begin
                    for (int k = 31; k >= 0; k--) begin
                        send_cell(button_word[k]);
                    end
                    send_cell(1'b1);
                end
            end
        end
    end

endmodule

//--- tests/n64_hub_chk.sv
`timescale 1ns/1ps

module n64_hub_chk #(
    parameter int num_ports = 4
) (
    input logic                 clk,
    input logic                 send_reset,
    input logic                 polling_enable,
    input logic                 poll_start,
    input logic [num_ports-1:0] line_low,
    input logic [num_ports-1:0] reader_busy,
    input logic [num_ports-1:0] report_valid,
    input logic [num_ports-1:0] report_error
);

    // a finished poll is either good or failed
    valid_or_error: assert property (@(posedge clk) disable iff (send_reset)
        (report_valid & report_error) == '0)
        else $error("valid and error together on ports %b", report_valid & report_error);

    // host stays off the line while the pad answers
    quiet_while_reading: assert property (@(posedge clk) disable iff (send_reset)
        (line_low & reader_busy) == '0)
        else $error("line driven low during a reply on ports %b", line_low & reader_busy);

    no_poll_when_off: assert property (@(posedge clk) disable iff (send_reset)
        !polling_enable |-> !poll_start)
        else $error("poll_start while polling is disabled");

endmodule

// reader busy picked out of the four port instances
bind n64_hub n64_hub_chk #(
    .num_ports(num_ports)
) chk_inst (
    .clk           (clk),
    .send_reset    (send_reset),
    .polling_enable(polling_enable),
    .poll_start    (poll_start),
    .line_low      (line_low),
    .reader_busy   ({gen_ports[3].port_inst.read_busy, gen_ports[2].port_inst.read_busy,
                     gen_ports[1].port_inst.read_busy, gen_ports[0].port_inst.read_busy}),
    .report_valid  (report_valid),
    .report_error  (report_error)
);

//--- tests/n64_hub_tb.sv
`timescale 1ns/1ps

module n64_hub_tb;

    localparam int num_ports      = 4;
    localparam int clks_per_us    = 4;
    localparam int poll_cycles    = 1000; // fits write, 32 bit reply and margin
    localparam int poll_count     = 14;   // polls over all tests
    localparam int idle_periods   = 4;    // length of the disabled stretch
    localparam int timeout_cycles = (poll_count + idle_periods + 5) * poll_cycles;

    logic                        clk;
    logic                        send_reset;
    logic                        polling_enable;
    logic                        controller_reset;
    logic [num_ports-1:0]        line;
    logic [num_ports-1:0]        line_low;
    logic [num_ports-1:0]        pad_drive;
    n64_report_pkg::reply_word_t button_data [num_ports];
    n64_report_pkg::reply_word_t pad_status [num_ports];
    logic [num_ports-1:0]        report_valid;
    logic [num_ports-1:0]        report_error;
    logic [31:0]                 pad_button [num_ports];
    logic [23:0]                 pad_status_word [num_ports];
    logic [num_ports-1:0]        pad_silent;
    logic [7:0]                  pad_command [num_ports];
    int                          pad_polls [num_ports];
    logic [31:0]                 rand_state;
    int                          cycle_count;
    int                          check_count;
    int                          error_count;

    assign line = ~line_low & ~pad_drive; // open drain, either side pulls low

    always #2 clk = ~clk;

    n64_hub #(
        .num_ports  (num_ports),
        .clks_per_us(clks_per_us),
        .poll_cycles(poll_cycles)
    ) n64_hub_inst (
        .clk(clk), .send_reset(send_reset),
        .polling_enable(polling_enable), .controller_reset(controller_reset),
        .line_in(line), .line_low(line_low),
        .button_data(button_data), .pad_status(pad_status),
        .report_valid(report_valid), .report_error(report_error)
    );

    for (genvar i = 0; i < num_ports; i++) begin : gen_pads
        n64_controller_model #(.clks_per_us(clks_per_us)) pad_inst (
            .clk(clk), .line(line[i]),
            .button_word(pad_button[i]), .status_word(pad_status_word[i]),
            .silent(pad_silent[i]), .drive_low(pad_drive[i]),
            .last_command(pad_command[i]), .command_count(pad_polls[i])
        );
    end

    // run limit, a few spare periods over the planned polls
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: no end of test after %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223; // LCG
    endfunction

    task automatic check(input logic ok, input string what);
        check_count++;
        assert (ok)
        else begin
            error_count++;
            $display("[ERROR] %0d ns: %s", $time, what);
        end
    endtask

    // fresh words for every pad
    task automatic load_words();
        for (int i = 0; i < num_ports; i++) begin
            rand_state         = next_random(rand_state);
            pad_button[i]      = rand_state;
            rand_state         = next_random(rand_state);
            pad_status_word[i] = rand_state[31:8];
        end
    endtask

    // collect one pulse per port, a silent pad reports before the rest
    task automatic wait_reports(output logic [num_ports-1:0] valid_seen,
                                output logic [num_ports-1:0] error_seen);
        int waited;
        valid_seen = '0;
        error_seen = '0;
        waited     = 0;
        while ((valid_seen | error_seen) != '1 && waited < 2 * poll_cycles) begin
            @(negedge clk);
            valid_seen = valid_seen | report_valid;
            error_seen = error_seen | report_error;
            waited++;
        end
        check_count++;
        assert ((valid_seen | error_seen) == '1)
        else begin
            error_count++;
            $display("ports %b never reported a poll", ~(valid_seen | error_seen));
        end
    endtask

    // good button poll on port i, also looks at the stick bytes
    task automatic check_buttons(input int i, input logic valid);
        check(valid, $sformatf("port %0d: no report_valid", i));
        check(pad_command[i] == 8'h01, $sformatf("port %0d: command %h, expected 01",
                                                 i, pad_command[i]));
        check(button_data[i] == pad_button[i], $sformatf("port %0d: button_data %h, expected %h",
                                                         i, button_data[i], pad_button[i]));
        check(button_data[i].button.stick_x == $signed(pad_button[i][15:8]),
              $sformatf("port %0d: stick x %0d", i, button_data[i].button.stick_x));
        check(button_data[i].button.stick_y == $signed(pad_button[i][7:0]),
              $sformatf("port %0d: stick y %0d", i, button_data[i].button.stick_y));
    endtask

    task automatic button_poll_test();
        logic [num_ports-1:0] valid_seen;
        logic [num_ports-1:0] error_seen;
        load_words();
        wait_reports(valid_seen, error_seen);
        for (int i = 0; i < num_ports; i++) begin
            check_buttons(i, valid_seen[i] && !error_seen[i]);
        end
    endtask

    task automatic reset_command_test();
        logic [num_ports-1:0] valid_seen;
        logic [num_ports-1:0] error_seen;
        logic [31:0]          old_buttons [num_ports];
        for (int i = 0; i < num_ports; i++) begin
            old_buttons[i] = button_data[i];
        end
        load_words();
        @(posedge clk);
        #1 controller_reset = 1'b1;
        @(posedge clk);
        #1 controller_reset = 1'b0;
        wait_reports(valid_seen, error_seen);
        for (int i = 0; i < num_ports; i++) begin
            check(valid_seen[i], $sformatf("port %0d: no report_valid for status", i));
            check(pad_command[i] == 8'hFF, $sformatf("port %0d: command %h, expected FF",
                                                     i, pad_command[i]));
            check(pad_status[i] == {pad_status_word[i], 8'h00},
                  $sformatf("port %0d: pad_status %h, expected %h00",
                            i, pad_status[i], pad_status_word[i]));
            check(button_data[i] == old_buttons[i],
                  $sformatf("port %0d: button_data moved on a status reply", i));
        end
        wait_reports(valid_seen, error_seen); // back to get buttons
        for (int i = 0; i < num_ports; i++) begin
            check_buttons(i, valid_seen[i]);
        end
    endtask

    task automatic silent_port_test();
        logic [num_ports-1:0] valid_seen;
        logic [num_ports-1:0] error_seen;
        logic [31:0]          old_word;
        old_word      = button_data[2];
        load_words();
        pad_silent[2] = 1'b1; // port 2 unplugged for one poll
        wait_reports(valid_seen, error_seen);
        check(error_seen[2] && !valid_seen[2], "port 2: no report_error for a silent pad");
        check(button_data[2] == old_word, $sformatf("port 2: button_data %h, old %h",
                                                    button_data[2], old_word));
        for (int i = 0; i < num_ports; i++) begin
            if (i != 2) begin
                check_buttons(i, valid_seen[i] && !error_seen[i]);
            end
        end
        pad_silent[2] = 1'b0;
    endtask

    task automatic disabled_test();
        int   polls_before [num_ports];
        logic quiet;
        quiet = 1'b1;
        for (int i = 0; i < num_ports; i++) begin
            polls_before[i] = pad_polls[i];
        end
        @(posedge clk);
        #1 polling_enable = 1'b0;
        repeat (idle_periods * poll_cycles) begin
            @(negedge clk);
            if (line_low != '0 || report_valid != '0 || report_error != '0) quiet = 1'b0;
        end
        check(quiet, "line or report activity while polling was off");
        for (int i = 0; i < num_ports; i++) begin
            check(pad_polls[i] == polls_before[i], $sformatf("port %0d: polled while off", i));
        end
        @(posedge clk);
        #1 polling_enable = 1'b1;
    endtask

    task automatic random_poll_test();
        logic [num_ports-1:0] valid_seen;
        logic [num_ports-1:0] error_seen;
        repeat (10) begin
            load_words();
            wait_reports(valid_seen, error_seen);
            for (int i = 0; i < num_ports; i++) begin
                check_buttons(i, valid_seen[i] && !error_seen[i]);
            end
        end
    endtask

    initial begin
        clk              = 1'b0;
        send_reset       = 1'b1;
        polling_enable   = 1'b0;
        controller_reset = 1'b0;
        pad_silent       = '0;
        rand_state       = 32'h461f;
        cycle_count      = 0;
        check_count      = 0;
        error_count      = 0;
        for (int i = 0; i < num_ports; i++) begin
            pad_button[i]      = '0;
            pad_status_word[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 send_reset = 0;
        check(line_low == '0 && report_valid == '0 && report_error == '0,
              "outputs not idle after reset");
        for (int i = 0; i < num_ports; i++) begin
            check(button_data[i] == '0 && pad_status[i] == '0,
                  $sformatf("port %0d: data not cleared by reset", i));
        end
        polling_enable = 1'b1;
        button_poll_test();
        reset_command_test();
        silent_port_test();
        disabled_test();
        random_poll_test();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/n64_proto_pkg.sv
verilog/n64_report_pkg.sv
verilog/n64_poll_timer.sv
verilog/n64_line_writer.sv
verilog/n64_line_reader.sv
verilog/n64_port.sv
verilog/n64_report_collector.sv
verilog/n64_hub.sv
tests/n64_controller_model.sv
tests/n64_hub_chk.sv
tests/n64_hub_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = n64_hub_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
